/* rowbuf_pkg.sv */
package rowbuf_pkg;

    ////////////////////////////////////////
    // Widths and sizes
    ////////////////////////////////////////

    localparam int PIXEL_W      = 16;
    localparam int BANK_DEPTH   = 1024;
    localparam int ADDR_W       = 10;
    // Bank address minus the row-half bit
    localparam int COL_W        = 9;
    localparam int SEQ_W        = 16;
    localparam int SEQ_ROW_BIT  = 15;
    // Sampled execute to valid data
    localparam int READ_LATENCY = 2;

    ////////////////////////////////////////
    // Types
    ////////////////////////////////////////

    typedef logic [PIXEL_W-1:0] pixel_t;

    // Odd bank in the upper half, even bank in the lower half
    typedef struct packed {
        pixel_t odd;
        pixel_t even;
    } pixel_pair_t;

    typedef logic [ADDR_W-1:0] addr_t;
    typedef logic [COL_W-1:0]  col_t;

    // Column in bits 8:0, row select in bit 15
    typedef logic [SEQ_W-1:0]  seq_t;

    // Row rotation code
    typedef logic [1:0]        gray_t;

    // Window controller states
    typedef enum logic [2:0] {
        IDLE      = 3'd0,
        PRIME     = 3'd1,
        WAIT_LOAD = 3'd2,
        ACTIVE    = 3'd3,
        FIN_ROW   = 3'd4,
        DONE      = 3'd5
    } rowbuf_state_e;

endpackage

/* row_bank_ram.sv */
`timescale 1ns/1ps

module row_bank_ram #(
    parameter int DEPTH = 1024,
    parameter int WIDTH = 16
) (
    input  logic                     clk,
    input  logic [$clog2(DEPTH)-1:0] wr_addr,
    input  logic [$clog2(DEPTH)-1:0] rd_addr,
    input  logic [WIDTH-1:0]         datain,
    input  logic                     wren,
    input  logic                     rden,
    output logic [WIDTH-1:0]         dataout
);

    // Block RAM storage
    logic [WIDTH-1:0] mem [DEPTH];

    // Write port
    always_ff @(posedge clk) begin
        if (wren) begin
            mem[wr_addr] <= datain;
        end
    end

    // Registered read port, holds its value while rden is low
    // Same-address read during a write returns the old word
    always_ff @(posedge clk) begin
        if (rden) begin
            dataout <= mem[rd_addr];
        end
    end

endmodule

/* delay_line.sv */
`timescale 1ns/1ps

module delay_line #(
    parameter type T     = logic,
    parameter int  DEPTH = 1
) (
    input  logic clk,
    input  logic rst,
    input  T     data_in,
    output T     data_out
);

    // One register per cycle of delay
    T stage [DEPTH];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < DEPTH; i++) begin
                stage[i] <= '0;
            end
        end else begin
            stage[0] <= data_in;
            // Shift toward the output end
            for (int i = 1; i < DEPTH; i++) begin
                stage[i] <= stage[i-1];
            end
        end
    end

    assign data_out = stage[DEPTH-1];

endmodule

/* seq_addr_gen.sv */
`timescale 1ns/1ps

module seq_addr_gen import rowbuf_pkg::*; (
    input  logic  clk,
    input  logic  rst,
    input  seq_t  seq_datain,
    input  gray_t gray_code,
    output addr_t ce0_even_addr,
    output addr_t ce0_odd_addr,
    output addr_t ce1_even_addr,
    output addr_t ce1_odd_addr
);

    seq_t  seq_d;
    gray_t gray_d;

    ////////////////////////////////////////
    // Engine 1 runs one cycle behind
    ////////////////////////////////////////

    delay_line #(
        .T     (seq_t),
        .DEPTH (1)
    ) u_seq_dly (
        .clk      (clk),
        .rst      (rst),
        .data_in  (seq_datain),
        .data_out (seq_d)
    );

    delay_line #(
        .T     (gray_t),
        .DEPTH (1)
    ) u_gray_dly (
        .clk      (clk),
        .rst      (rst),
        .data_in  (gray_code),
        .data_out (gray_d)
    );

    ////////////////////////////////////////
    // Address decode
    ////////////////////////////////////////

    // Row bit rotated by one gray bit, then the column
    function automatic addr_t bank_addr(input seq_t seq, input logic gray_bit);
        return {seq[SEQ_ROW_BIT] ^ gray_bit, seq[COL_W-1:0]};
    endfunction

    assign ce0_even_addr = bank_addr(seq_datain, gray_code[0]);
    assign ce0_odd_addr  = bank_addr(seq_datain, gray_code[1]);

    assign ce1_even_addr = bank_addr(seq_d, gray_d[0]);
    assign ce1_odd_addr  = bank_addr(seq_d, gray_d[1]);

endmodule

/* ce_row_buffer.sv */
`timescale 1ns/1ps

module ce_row_buffer import rowbuf_pkg::*; (
    input  logic          clk,
    input  logic          rst,
    input  rowbuf_state_e state,
    input  col_t          input_row,
    input  col_t          input_col,
    input  col_t          num_input_cols,
    input  col_t          wr_col,
    input  gray_t         gray_code,
    input  logic          pfb_rden,
    input  logic          row_matric,
    input  logic          last_kernel,
    input  logic          execute,
    input  pixel_t        pixel_datain,
    input  addr_t         even_addr,
    input  addr_t         odd_addr,
    output pixel_pair_t   pixel_dataout,
    output logic          dataout_valid
);

    // Request decode
    logic   prime_en;
    logic   prime_row0;
    logic   prime_row1;
    logic   prime_row2;
    logic   repl_en;
    logic   repl_odd;
    logic   rd_en;
    logic   even_wr_req;
    logic   odd_wr_req;
    addr_t  even_wr_addr_nxt;
    addr_t  odd_wr_addr_nxt;

    // Bank port registers
    logic   even_wren;
    logic   odd_wren;
    logic   even_rden;
    logic   odd_rden;
    addr_t  even_wr_addr;
    addr_t  odd_wr_addr;
    addr_t  even_rd_addr;
    addr_t  odd_rd_addr;
    pixel_t even_wr_data;
    pixel_t odd_wr_data;
    pixel_t even_dout;
    pixel_t odd_dout;

    ////////////////////////////////////////
    // Priming, replacement and read decode
    ////////////////////////////////////////

    assign prime_en   = (state == PRIME) && pfb_rden && (input_col <= num_input_cols);
    assign prime_row0 = (input_row == col_t'(0));
    assign prime_row1 = (input_row == col_t'(1));
    assign prime_row2 = (input_row == col_t'(2));

    // Stale row replaced while the window slides
    assign repl_en  = ((state == ACTIVE) || (state == FIN_ROW)) && row_matric && last_kernel;
    assign repl_odd = (gray_code[0] == gray_code[1]);

    assign rd_en = (state == ACTIVE) && execute;

    // Row 0 fills both lower halves, rows 1 and 2 take one upper half each
    assign even_wr_req = (prime_en && (prime_row0 || prime_row2)) || (repl_en && !repl_odd);
    assign odd_wr_req  = (prime_en && (prime_row0 || prime_row1)) || (repl_en && repl_odd);

    assign even_wr_addr_nxt = repl_en ? {gray_code[0], wr_col} : {prime_row2, input_col};
    assign odd_wr_addr_nxt  = repl_en ? {gray_code[0], wr_col} : {prime_row1, input_col};

    // Enables
    always_ff @(posedge clk) begin
        if (rst) begin
            even_wren <= 1'b0;
            odd_wren  <= 1'b0;
            even_rden <= 1'b0;
            odd_rden  <= 1'b0;
        end else begin
            even_wren <= even_wr_req;
            odd_wren  <= odd_wr_req;
            even_rden <= rd_en;
            odd_rden  <= rd_en;
        end
    end

    // Addresses and write data
    always_ff @(posedge clk) begin
        if (even_wr_req) begin
            even_wr_addr <= even_wr_addr_nxt;
            even_wr_data <= pixel_datain;
        end
        if (odd_wr_req) begin
            odd_wr_addr <= odd_wr_addr_nxt;
            odd_wr_data <= pixel_datain;
        end
        if (rd_en) begin
            even_rd_addr <= even_addr;
            odd_rd_addr  <= odd_addr;
        end
    end

    ////////////////////////////////////////
    // Banks
    ////////////////////////////////////////

    row_bank_ram #(
        .DEPTH (BANK_DEPTH),
        .WIDTH (PIXEL_W)
    ) u_even_bank (
        .clk     (clk),
        .wr_addr (even_wr_addr),
        .rd_addr (even_rd_addr),
        .datain  (even_wr_data),
        .wren    (even_wren),
        .rden    (even_rden),
        .dataout (even_dout)
    );

    row_bank_ram #(
        .DEPTH (BANK_DEPTH),
        .WIDTH (PIXEL_W)
    ) u_odd_bank (
        .clk     (clk),
        .wr_addr (odd_wr_addr),
        .rd_addr (odd_rd_addr),
        .datain  (odd_wr_data),
        .wren    (odd_wren),
        .rden    (odd_rden),
        .dataout (odd_dout)
    );

    // Output register, data lines up with valid
    always_ff @(posedge clk) begin
        pixel_dataout.odd  <= odd_dout;
        pixel_dataout.even <= even_dout;
    end

    // Valid follows the read enable through the RAM and output registers
    delay_line #(
        .T     (logic),
        .DEPTH (READ_LATENCY)
    ) u_valid_dly (
        .clk      (clk),
        .rst      (rst),
        .data_in  (even_rden),
        .data_out (dataout_valid)
    );

endmodule

/* awe_row_buffers.sv */
`timescale 1ns/1ps

module awe_row_buffers import rowbuf_pkg::*; (
    input  logic          clk,
    input  logic          rst,
    input  rowbuf_state_e state,
    input  col_t          input_row,
    input  col_t          input_col,
    input  col_t          num_input_cols,
    input  gray_t         gray_code,
    input  seq_t          seq_datain,
    input  logic          pfb_rden,
    input  logic          last_kernel,
    input  logic          row_matric,
    input  pixel_t        ce0_pixel_datain,
    input  pixel_t        ce1_pixel_datain,
    input  logic          ce0_execute,
    input  logic          ce1_execute,
    input  col_t          wr_col,
    output pixel_pair_t   ce0_pixel_dataout,
    output pixel_pair_t   ce1_pixel_dataout,
    output logic          ce0_dataout_valid,
    output logic          ce1_dataout_valid
);

    // Read addresses per engine
    addr_t ce0_even_addr;
    addr_t ce0_odd_addr;
    addr_t ce1_even_addr;
    addr_t ce1_odd_addr;

    seq_addr_gen u_seq_addr_gen (
        .clk           (clk),
        .rst           (rst),
        .seq_datain    (seq_datain),
        .gray_code     (gray_code),
        .ce0_even_addr (ce0_even_addr),
        .ce0_odd_addr  (ce0_odd_addr),
        .ce1_even_addr (ce1_even_addr),
        .ce1_odd_addr  (ce1_odd_addr)
    );

    ////////////////////////////////////////
    // Convolution engines
    ////////////////////////////////////////

    ce_row_buffer u_ce0 (
        .clk            (clk),
        .rst            (rst),
        .state          (state),
        .input_row      (input_row),
        .input_col      (input_col),
        .num_input_cols (num_input_cols),
        .wr_col         (wr_col),
        .gray_code      (gray_code),
        .pfb_rden       (pfb_rden),
        .row_matric     (row_matric),
        .last_kernel    (last_kernel),
        .execute        (ce0_execute),
        .pixel_datain   (ce0_pixel_datain),
        .even_addr      (ce0_even_addr),
        .odd_addr       (ce0_odd_addr),
        .pixel_dataout  (ce0_pixel_dataout),
        .dataout_valid  (ce0_dataout_valid)
    );

    // Engine 1 reads with the previous cycle's sequencer word
    ce_row_buffer u_ce1 (
        .clk            (clk),
        .rst            (rst),
        .state          (state),
        .input_row      (input_row),
        .input_col      (input_col),
        .num_input_cols (num_input_cols),
        .wr_col         (wr_col),
        .gray_code      (gray_code),
        .pfb_rden       (pfb_rden),
        .row_matric     (row_matric),
        .last_kernel    (last_kernel),
        .execute        (ce1_execute),
        .pixel_datain   (ce1_pixel_datain),
        .even_addr      (ce1_even_addr),
        .odd_addr       (ce1_odd_addr),
        .pixel_dataout  (ce1_pixel_dataout),
        .dataout_valid  (ce1_dataout_valid)
    );

endmodule

/* tb_awe_row_buffers.sv */
`timescale 1ns/1ps

module tb_awe_row_buffers import rowbuf_pkg::*; ();

    localparam int DRAIN_LIMIT = 16;

    logic          clk;
    logic          rst;
    rowbuf_state_e state;
    col_t          input_row;
    col_t          input_col;
    col_t          num_input_cols;
    gray_t         gray_code;
    seq_t          seq_datain;
    logic          pfb_rden;
    logic          last_kernel;
    logic          row_matric;
    pixel_t        ce0_pixel_datain;
    pixel_t        ce1_pixel_datain;
    logic          ce0_execute;
    logic          ce1_execute;
    col_t          wr_col;
    pixel_pair_t   ce0_pixel_dataout;
    pixel_pair_t   ce1_pixel_dataout;
    logic          ce0_dataout_valid;
    logic          ce1_dataout_valid;

    // Reference model of both engines' banks
    pixel_t        even_mem [2][BANK_DEPTH];
    pixel_t        odd_mem  [2][BANK_DEPTH];
    pixel_pair_t   exp_q0 [$];
    pixel_pair_t   exp_q1 [$];
    logic          valid_pipe0 [READ_LATENCY+1];
    logic          valid_pipe1 [READ_LATENCY+1];
    seq_t          seq_prev;
    gray_t         gray_prev;
    logic [31:0]   rng_state;
    col_t          repl_cols [$];
    rowbuf_state_e quiet_states [5] = '{IDLE, PRIME, WAIT_LOAD, FIN_ROW, DONE};

    always #50 clk = ~clk;

    awe_row_buffers u_dut (
        .clk               (clk),
        .rst               (rst),
        .state             (state),
        .input_row         (input_row),
        .input_col         (input_col),
        .num_input_cols    (num_input_cols),
        .gray_code         (gray_code),
        .seq_datain        (seq_datain),
        .pfb_rden          (pfb_rden),
        .last_kernel       (last_kernel),
        .row_matric        (row_matric),
        .ce0_pixel_datain  (ce0_pixel_datain),
        .ce1_pixel_datain  (ce1_pixel_datain),
        .ce0_execute       (ce0_execute),
        .ce1_execute       (ce1_execute),
        .wr_col            (wr_col),
        .ce0_pixel_dataout (ce0_pixel_dataout),
        .ce1_pixel_dataout (ce1_pixel_dataout),
        .ce0_dataout_valid (ce0_dataout_valid),
        .ce1_dataout_valid (ce1_dataout_valid)
    );

    ////////////////////////////////////////
    // Random numbers and checks
    ////////////////////////////////////////

    function automatic logic [31:0] rand32();
        logic [31:0] x;
        x = rng_state;
        x ^= x << 13;
        x ^= x >> 17;
        x ^= x << 5;
        rng_state = x;
        return x;
    endfunction

    task automatic abort_run();
        $display("tests failed");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_pixel_pair(input pixel_pair_t got, input pixel_pair_t exp,
                                    input string what);
        if (got !== exp) begin
            $display("mismatch at %0t: %s got %h expected %h", $time, what, got, exp);
            abort_run();
        end
    endtask

    task automatic check_valid(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            $display("mismatch at %0t: %s got %b expected %b", $time, what, got, exp);
            abort_run();
        end
    endtask

    ////////////////////////////////////////
    // Reference model
    ////////////////////////////////////////

    function automatic pixel_pair_t model_read(input int eng, input seq_t s, input gray_t g);
        addr_t       ea;
        addr_t       oa;
        pixel_pair_t p;
        ea     = {s[SEQ_ROW_BIT] ^ g[0], s[COL_W-1:0]};
        oa     = {s[SEQ_ROW_BIT] ^ g[1], s[COL_W-1:0]};
        p.even = even_mem[eng][ea];
        p.odd  = odd_mem[eng][oa];
        return p;
    endfunction

    task automatic model_write(input int eng, input pixel_t p);
        if (state == PRIME && pfb_rden && input_col <= num_input_cols) begin
            case (input_row)
                0: begin
                    even_mem[eng][{1'b0, input_col}] = p;
                    odd_mem[eng][{1'b0, input_col}]  = p;
                end
                1: odd_mem[eng][{1'b1, input_col}]  = p;
                2: even_mem[eng][{1'b1, input_col}] = p;
                default: ;
            endcase
        end
        // Stale row overwrite
        if ((state == ACTIVE || state == FIN_ROW) && row_matric && last_kernel) begin
            if (gray_code[0] == gray_code[1]) begin
                odd_mem[eng][{gray_code[0], wr_col}] = p;
            end else begin
                even_mem[eng][{gray_code[0], wr_col}] = p;
            end
        end
    endtask

    // Apply this cycle's inputs to the model, then advance to the next falling edge
    task automatic tick();
        logic rd0;
        logic rd1;
        int   i;
        rd0 = !rst && state == ACTIVE && ce0_execute;
        rd1 = !rst && state == ACTIVE && ce1_execute;
        // Reads see memory before this cycle's writes land
        if (rd0) exp_q0.push_back(model_read(0, seq_datain, gray_code));
        if (rd1) exp_q1.push_back(model_read(1, seq_prev, gray_prev));
        if (!rst) begin
            model_write(0, ce0_pixel_datain);
            model_write(1, ce1_pixel_datain);
        end
        for (i = READ_LATENCY; i > 0; i--) begin
            valid_pipe0[i] = valid_pipe0[i-1];
            valid_pipe1[i] = valid_pipe1[i-1];
        end
        valid_pipe0[0] = rd0;
        valid_pipe1[0] = rd1;
        seq_prev  = rst ? '0 : seq_datain;
        gray_prev = rst ? '0 : gray_code;
        @(negedge clk);
        check_valid(ce0_dataout_valid, valid_pipe0[READ_LATENCY], "engine 0 valid");
        check_valid(ce1_dataout_valid, valid_pipe1[READ_LATENCY], "engine 1 valid");
        if (valid_pipe0[READ_LATENCY]) begin
            check_pixel_pair(ce0_pixel_dataout, exp_q0.pop_front(), "engine 0 data");
        end
        if (valid_pipe1[READ_LATENCY]) begin
            check_pixel_pair(ce1_pixel_dataout, exp_q1.pop_front(), "engine 1 data");
        end
    endtask

    ////////////////////////////////////////
    // Stimulus
    ////////////////////////////////////////

    task automatic new_pixels();
        ce0_pixel_datain = pixel_t'(rand32());
        ce1_pixel_datain = pixel_t'(rand32());
    endtask

    task automatic clear_strobes();
        pfb_rden    = 1'b0;
        row_matric  = 1'b0;
        last_kernel = 1'b0;
        ce0_execute = 1'b0;
        ce1_execute = 1'b0;
    endtask

    task automatic drain_reads();
        int n;
        clear_strobes();
        n = 0;
        while (exp_q0.size() != 0 || exp_q1.size() != 0) begin
            if (n >= DRAIN_LIMIT) begin
                $display("timeout: read data did not arrive within %0d cycles", DRAIN_LIMIT);
                abort_run();
            end else begin
                new_pixels();
                tick();
                n++;
            end
        end
    endtask

    // Rows 0 to 2 over every column, then a few row 3 loads that must be ignored
    task automatic prime_rows(input col_t ncols);
        int row;
        int col;
        num_input_cols = ncols;
        state          = PRIME;
        pfb_rden       = 1'b1;
        for (row = 0; row < 3; row++) begin
            for (col = 0; col < 512; col++) begin
                input_row = col_t'(row);
                input_col = col_t'(col);
                new_pixels();
                tick();
            end
        end
        for (col = 0; col < 8; col++) begin
            input_row = col_t'(3);
            input_col = col_t'(rand32());
            new_pixels();
            tick();
        end
        pfb_rden = 1'b0;
        state    = WAIT_LOAD;
        tick();
    endtask

    task automatic random_reads(input rowbuf_state_e st, input int cycles);
        int i;
        state = st;
        for (i = 0; i < cycles; i++) begin
            seq_datain  = seq_t'(rand32());
            gray_code   = gray_t'(rand32());
            ce0_execute = (rand32() % 4) != 0;
            ce1_execute = (rand32() % 4) != 0;
            new_pixels();
            tick();
        end
        drain_reads();
    endtask

    task automatic replace_rows(input rowbuf_state_e st);
        int g;
        int i;
        for (g = 0; g < 4; g++) begin
            repl_cols.delete();
            state     = st;
            gray_code = gray_t'(g);
            for (i = 0; i < 16; i++) begin
                wr_col      = col_t'(rand32());
                row_matric  = (rand32() % 4) != 0;
                last_kernel = (rand32() % 4) != 0;
                // Row_matric alone is read back too, it must leave the column alone
                if (row_matric) repl_cols.push_back(wr_col);
                new_pixels();
                tick();
            end
            row_matric  = 1'b0;
            last_kernel = 1'b0;
            tick();
            tick();
            // Row bit 0 points both banks at the replaced half
            state = ACTIVE;
            for (i = 0; i < repl_cols.size(); i++) begin
                seq_datain              = seq_t'(rand32());
                seq_datain[SEQ_ROW_BIT] = 1'b0;
                seq_datain[COL_W-1:0]   = repl_cols[i];
                ce0_execute             = 1'b1;
                ce1_execute             = 1'b1;
                new_pixels();
                tick();
            end
            drain_reads();
        end
    endtask

    initial begin
        rng_state      = 32'hc00eda11;
        clk            = 1'b0;
        rst            = 1'b1;
        state          = IDLE;
        input_row      = '0;
        input_col      = '0;
        num_input_cols = '0;
        gray_code      = '0;
        seq_datain     = '0;
        wr_col         = '0;
        seq_prev       = '0;
        gray_prev      = '0;
        clear_strobes();
        new_pixels();
        for (int i = 0; i <= READ_LATENCY; i++) begin
            valid_pipe0[i] = 1'b0;
            valid_pipe1[i] = 1'b0;
        end
        repeat (8) tick();
        rst = 1'b0;
        repeat (4) tick();

        prime_rows(col_t'(511));
        random_reads(ACTIVE, 200);

        // Partial reload leaves the upper columns untouched
        prime_rows(col_t'(rand32() % 511));
        random_reads(ACTIVE, 200);

        foreach (quiet_states[i]) begin
            random_reads(quiet_states[i], 20);
        end

        replace_rows(ACTIVE);
        replace_rows(FIN_ROW);
        random_reads(ACTIVE, 100);

        $display("all tests passed");
        $finish;
    end

endmodule

/* sim.f */
rowbuf_pkg.sv
row_bank_ram.sv
delay_line.sv
seq_addr_gen.sv
ce_row_buffer.sv
awe_row_buffers.sv
tb_awe_row_buffers.sv
